// ==== files.f ====
+incdir+rtl
rtl/bpu_isa_pkg.sv
rtl/bpu_pred_pkg.sv
rtl/inst_predecode.sv
rtl/tage_tagged_table.sv
rtl/tage_predictor.sv
rtl/btb.sv
rtl/return_stack.sv
rtl/bpu_top.sv
tests/bpu_tb.sv

// ==== rtl/bpu_isa_pkg.sv ====
package bpu_isa_pkg;

    // major opcodes of control transfers
    localparam logic [6:0] BRANCH = 7'b1100011;
    localparam logic [6:0] JAL    = 7'b1101111;
    localparam logic [6:0] JALR   = 7'b1100111;

    localparam logic [4:0] REG_ZERO = 5'd0;
    localparam logic [4:0] REG_RA   = 5'd1;  // link register x1

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // one fetched word, read as branch, jump or jalr
    typedef union packed {
        b_fmt_t b_fmt;
        j_fmt_t j_fmt;
        i_fmt_t i_fmt;
    } inst_u;

endpackage

// ==== rtl/bpu_pred_pkg.sv ====
`include "bpu_settings.svh"

package bpu_pred_pkg;

    typedef logic [1:0] ctr2_t;  // msb set means taken

    localparam ctr2_t CTR_STRONG_NT = 2'd0;
    localparam ctr2_t CTR_WEAK_NT   = 2'd1;
    localparam ctr2_t CTR_WEAK_T    = 2'd2;
    localparam ctr2_t CTR_STRONG_T  = 2'd3;

    typedef enum logic [1:0] {
        PROV_BIMODAL = 2'd0,
        PROV_T0      = 2'd1,
        PROV_T1      = 2'd2
    } provider_e;

    typedef enum logic [1:0] {
        UPD_TRAIN = 2'd0,
        UPD_RESET = 2'd1,
        UPD_ALLOC = 2'd2
    } upd_mode_e;

    typedef logic [`TAG_WIDTH-1:0] tage_tag_t;

    // saturating step toward the resolved direction
    function automatic ctr2_t ctr_step(ctr2_t ctr, logic taken);
        if (taken)
            return (ctr == CTR_STRONG_T) ? ctr : ctr + 2'd1;
        return (ctr == CTR_STRONG_NT) ? ctr : ctr - 2'd1;
    endfunction

endpackage

// ==== rtl/bpu_settings.svh ====
`ifndef BPU_SETTINGS_SVH
`define BPU_SETTINGS_SVH

`define XLEN             32
`define HIST_LEN         16   // global history bits
`define BIMODAL_ENTRIES  512
`define TAGGED_ENTRIES   256  // per tagged table
`define TAG_WIDTH        10
`define PARTIAL_TAG_BITS 6    // upper tag bits used at lookup
`define BTB_ENTRIES      256
`define BTB_TAG_WIDTH    22
`define RAS_DEPTH        32

`endif

// ==== rtl/bpu_top.sv ====
`timescale 1ns/100ps
`include "bpu_settings.svh"

module bpu_top (
    input  logic                    clk,
    input  logic                    rst,
    // fetch
    input  logic [`XLEN-1:0]        if_pc_i,
    input  logic [`XLEN-1:0]        if_inst_i,
    // decode
    input  logic                    id_ras_push_valid_i,
    input  logic [`XLEN-1:0]        id_ras_push_data_i,
    input  logic                    ex_stall_valid_i,
    // execute feedback
    input  logic                    ex_branch_valid_i,
    input  logic                    ex_branch_taken_i,
    input  logic                    ex_pdt_true_i,
    input  logic [`XLEN-1:0]        ex_pc_i,
    input  logic [`HIST_LEN-1:0]    ex_history_i,
    input  bpu_pred_pkg::provider_e ex_provider_i,
    input  logic [`XLEN-1:0]        ex_target_i,
    input  logic [`XLEN-1:0]        ex_inst_i,
    // prediction
    output logic                    branch_or_not_o,
    output logic [`XLEN-1:0]        pdt_pc_o,
    output logic                    pdt_res_o,
    output logic [`HIST_LEN-1:0]    history_o,
    output bpu_pred_pkg::provider_e provider_o
);

    logic             is_branch, is_jal, is_jalr, is_ret, ex_is_ret;
    logic [`XLEN-1:0] b_offset, j_offset, pc_plus4;
    logic             tage_taken, btb_hit, ras_empty, ras_push, ras_pop;
    logic [`XLEN-1:0] btb_target, ras_top;

    assign pc_plus4 = if_pc_i + `XLEN'd4;
    assign ras_push = id_ras_push_valid_i && !ex_stall_valid_i;
    assign ras_pop  = ex_branch_valid_i && ex_branch_taken_i && ex_is_ret;

    always_comb begin
        branch_or_not_o = 1'b0;
        pdt_res_o       = 1'b0;
        pdt_pc_o        = pc_plus4;
        if (is_ret) begin
            branch_or_not_o = 1'b1;
            if (!ras_empty) begin
                pdt_res_o = 1'b1;
                pdt_pc_o  = ras_top;
            end else if (btb_hit) begin    // empty stack falls back to btb
                pdt_res_o = 1'b1;
                pdt_pc_o  = btb_target;
            end
        end else if (is_jal) begin
            branch_or_not_o = 1'b1;
            pdt_res_o       = 1'b1;
            pdt_pc_o        = btb_hit ? btb_target : if_pc_i + j_offset;
        end else if (is_branch || is_jalr) begin
            branch_or_not_o = 1'b1;
            pdt_res_o       = tage_taken;
            if (tage_taken && btb_hit)
                pdt_pc_o = btb_target;
            else if (tage_taken && is_branch)
                pdt_pc_o = if_pc_i + b_offset;
        end
    end

    inst_predecode fetch_decode (
        .inst_i        (if_inst_i),
        .is_branch_o   (is_branch),
        .is_jal_o      (is_jal),
        .is_jalr_o     (is_jalr),
        .is_ret_o      (is_ret),
        .is_ret_exec_o (),
        .b_offset_o    (b_offset),
        .j_offset_o    (j_offset)
    );

    // only the return check is needed at execute
    inst_predecode exec_decode (
        .inst_i        (ex_inst_i),
        .is_branch_o   (),
        .is_jal_o      (),
        .is_jalr_o     (),
        .is_ret_o      (),
        .is_ret_exec_o (ex_is_ret),
        .b_offset_o    (),
        .j_offset_o    ()
    );

    tage_predictor tage_predictor_i (
        .clk            (clk),
        .rst            (rst),
        .pc_i           (if_pc_i),
        .taken_pred_o   (tage_taken),
        .provider_o     (provider_o),
        .history_o      (history_o),
        .upd_valid_i    (ex_branch_valid_i),
        .upd_taken_i    (ex_branch_taken_i),
        .upd_correct_i  (ex_pdt_true_i),
        .upd_pc_i       (ex_pc_i),
        .upd_history_i  (ex_history_i),
        .upd_provider_i (ex_provider_i)
    );

    btb btb_i (
        .clk         (clk),
        .rst         (rst),
        .pc_i        (if_pc_i),
        .hit_o       (btb_hit),
        .target_o    (btb_target),
        .wr_en_i     (ex_branch_valid_i && ex_branch_taken_i),
        .wr_pc_i     (ex_pc_i),
        .wr_target_i (ex_target_i)
    );

    return_stack return_stack_i (
        .clk         (clk),
        .rst         (rst),
        .push_i      (ras_push),
        .push_addr_i (id_ras_push_data_i),
        .pop_i       (ras_pop),
        .empty_o     (ras_empty),
        .top_o       (ras_top)
    );

endmodule

// ==== rtl/btb.sv ====
`timescale 1ns/100ps
`include "bpu_settings.svh"

module btb (
    input  logic             clk,
    input  logic             rst,
    input  logic [`XLEN-1:0] pc_i,
    output logic             hit_o,
    output logic [`XLEN-1:0] target_o,
    input  logic             wr_en_i,
    input  logic [`XLEN-1:0] wr_pc_i,
    input  logic [`XLEN-1:0] wr_target_i
);

    localparam int IDX_W = $clog2(`BTB_ENTRIES);

    logic                      valid_q  [`BTB_ENTRIES];
    logic [`BTB_TAG_WIDTH-1:0] tag_mem  [`BTB_ENTRIES];
    logic [`XLEN-1:0]          targ_mem [`BTB_ENTRIES];

    logic [IDX_W-1:0] rd_idx, wr_idx;

    assign rd_idx = pc_i[IDX_W+1:2];     // word aligned
    assign wr_idx = wr_pc_i[IDX_W+1:2];

    assign hit_o    = valid_q[rd_idx] && (tag_mem[rd_idx] == pc_i[`XLEN-1:IDX_W+2]);
    assign target_o = targ_mem[rd_idx];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `BTB_ENTRIES; i++)
                valid_q[i] <= 1'b0;
        end else if (wr_en_i) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target follow the valid bit
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_idx]  <= wr_pc_i[`XLEN-1:IDX_W+2];
            targ_mem[wr_idx] <= wr_target_i;
        end
    end

endmodule

// ==== rtl/inst_predecode.sv ====
`timescale 1ns/100ps
`include "bpu_settings.svh"

module inst_predecode (
    input  bpu_isa_pkg::inst_u inst_i,
    output logic               is_branch_o,
    output logic               is_jal_o,
    output logic               is_jalr_o,
    output logic               is_ret_o,
    output logic               is_ret_exec_o,
    output logic [`XLEN-1:0]   b_offset_o,
    output logic [`XLEN-1:0]   j_offset_o
);

    logic [6:0] opcode;

    assign opcode = inst_i.i_fmt.opcode;  // same position in every view

    assign is_branch_o = (opcode == bpu_isa_pkg::BRANCH);
    assign is_jal_o    = (opcode == bpu_isa_pkg::JAL);
    assign is_jalr_o   = (opcode == bpu_isa_pkg::JALR);

    // strict return: jalr x0, 0(ra)
    assign is_ret_o = is_jalr_o
                   && (inst_i.i_fmt.rd == bpu_isa_pkg::REG_ZERO)
                   && (inst_i.i_fmt.rs1 == bpu_isa_pkg::REG_RA)
                   && (inst_i.i_fmt.imm == 12'd0);

    // execute side only looks at rs1
    assign is_ret_exec_o = is_jalr_o && (inst_i.i_fmt.rs1 == bpu_isa_pkg::REG_RA);

    assign b_offset_o = {{(`XLEN-12){inst_i.b_fmt.imm12}},
                         inst_i.b_fmt.imm11,
                         inst_i.b_fmt.imm10_5,
                         inst_i.b_fmt.imm4_1,
                         1'b0};

    assign j_offset_o = {{(`XLEN-20){inst_i.j_fmt.imm20}},
                         inst_i.j_fmt.imm19_12,
                         inst_i.j_fmt.imm11,
                         inst_i.j_fmt.imm10_1,
                         1'b0};

endmodule

// ==== rtl/return_stack.sv ====
`timescale 1ns/100ps
`include "bpu_settings.svh"

module return_stack (
    input  logic             clk,
    input  logic             rst,
    input  logic             push_i,
    input  logic [`XLEN-1:0] push_addr_i,
    input  logic             pop_i,
    output logic             empty_o,
    output logic [`XLEN-1:0] top_o
);

    localparam int PTR_W = $clog2(`RAS_DEPTH);

    logic [`XLEN-1:0] stack_mem [`RAS_DEPTH];
    logic [PTR_W:0]   sp_q;     // next free slot, one extra bit for full
    logic [PTR_W-1:0] top_idx;
    logic             full, do_pop, replace, do_push;

    assign empty_o = (sp_q == '0);
    assign full    = (sp_q == (PTR_W+1)'(`RAS_DEPTH));
    assign top_idx = PTR_W'(sp_q - 1'b1);
    assign top_o   = stack_mem[top_idx];

    assign do_pop  = pop_i && !empty_o;
    assign replace = push_i && do_pop;       // call and return in the same cycle
    assign do_push = push_i && !do_pop && !full;

    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            sp_q <= '0;
        else if (do_push)
            sp_q <= sp_q + 1'b1;
        else if (do_pop && !replace)
            sp_q <= sp_q - 1'b1;
    end

    always_ff @(posedge clk) begin
        if (replace)
            stack_mem[top_idx] <= push_addr_i;  // overwrite top, sp unchanged
        else if (do_push)
            stack_mem[sp_q[PTR_W-1:0]] <= push_addr_i;
    end

    sp_in_range: assert property (
        @(posedge clk) disable iff (rst) sp_q <= (PTR_W+1)'(`RAS_DEPTH)
    );

endmodule

// ==== rtl/tage_predictor.sv ====
`timescale 1ns/100ps
`include "bpu_settings.svh"

module tage_predictor (
    input  logic                    clk,
    input  logic                    rst,
    input  logic [`XLEN-1:0]        pc_i,
    output logic                    taken_pred_o,
    output bpu_pred_pkg::provider_e provider_o,
    output logic [`HIST_LEN-1:0]    history_o,
    input  logic                    upd_valid_i,
    input  logic                    upd_taken_i,
    input  logic                    upd_correct_i,
    input  logic [`XLEN-1:0]        upd_pc_i,
    input  logic [`HIST_LEN-1:0]    upd_history_i,
    input  bpu_pred_pkg::provider_e upd_provider_i
);

    localparam int BIM_W = $clog2(`BIMODAL_ENTRIES);

    logic [`HIST_LEN-1:0] hist_q;
    bpu_pred_pkg::ctr2_t  bim_mem [`BIMODAL_ENTRIES];

    logic [7:0]              t0_idx, t1_idx, t0_idx_u, t1_idx_u;
    bpu_pred_pkg::tage_tag_t t0_tag, t1_tag, t0_tag_u, t1_tag_u;
    logic                    t0_match, t1_match, t0_tag_hit, t1_tag_hit;
    bpu_pred_pkg::ctr2_t     t0_ctr, t1_ctr, sel_ctr;
    logic                    t0_upd_en, t1_upd_en, bim_wrong;
    bpu_pred_pkg::upd_mode_e t0_upd_mode, t1_upd_mode;

    // lookup hashes on the fetch pc and live history
    assign t0_idx = pc_i[7:0] ^ hist_q[7:0];
    assign t1_idx = pc_i[7:0] ^ hist_q[15:8];
    assign t0_tag = pc_i[17:8] ^ hist_q[15:6];
    assign t1_tag = pc_i[17:8] ^ {{(`TAG_WIDTH-8){1'b0}}, hist_q[7:0]};

    // same hashes with the history the branch was predicted under
    assign t0_idx_u = upd_pc_i[7:0] ^ upd_history_i[7:0];
    assign t1_idx_u = upd_pc_i[7:0] ^ upd_history_i[15:8];
    assign t0_tag_u = upd_pc_i[17:8] ^ upd_history_i[15:6];
    assign t1_tag_u = upd_pc_i[17:8] ^ {{(`TAG_WIDTH-8){1'b0}}, upd_history_i[7:0]};

    // longest history wins
    always_comb begin
        if (t1_match) begin
            provider_o = bpu_pred_pkg::PROV_T1;
            sel_ctr    = t1_ctr;
        end else if (t0_match) begin
            provider_o = bpu_pred_pkg::PROV_T0;
            sel_ctr    = t0_ctr;
        end else begin
            provider_o = bpu_pred_pkg::PROV_BIMODAL;
            sel_ctr    = bim_mem[pc_i[BIM_W:1]];
        end
    end

    assign taken_pred_o = sel_ctr[1];
    assign history_o    = hist_q;

    // a wrong bimodal guess allocates, t1 first
    assign bim_wrong = (upd_provider_i == bpu_pred_pkg::PROV_BIMODAL) && !upd_correct_i;

    assign t1_upd_en = upd_valid_i && ((upd_provider_i == bpu_pred_pkg::PROV_T1)
                                       || (bim_wrong && !t1_tag_hit));
    assign t0_upd_en = upd_valid_i && ((upd_provider_i == bpu_pred_pkg::PROV_T0)
                                       || (bim_wrong && t1_tag_hit && !t0_tag_hit));

    assign t1_upd_mode = (upd_provider_i != bpu_pred_pkg::PROV_T1) ? bpu_pred_pkg::UPD_ALLOC
                       : upd_correct_i ? bpu_pred_pkg::UPD_TRAIN : bpu_pred_pkg::UPD_RESET;
    assign t0_upd_mode = (upd_provider_i != bpu_pred_pkg::PROV_T0) ? bpu_pred_pkg::UPD_ALLOC
                       : upd_correct_i ? bpu_pred_pkg::UPD_TRAIN : bpu_pred_pkg::UPD_RESET;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hist_q <= '0;
            for (int i = 0; i < `BIMODAL_ENTRIES; i++)
                bim_mem[i] <= bpu_pred_pkg::CTR_WEAK_NT;
        end else if (upd_valid_i) begin
            hist_q <= {hist_q[`HIST_LEN-2:0], upd_taken_i};  // newest outcome in lsb
            bim_mem[upd_pc_i[BIM_W:1]] <= bpu_pred_pkg::ctr_step(bim_mem[upd_pc_i[BIM_W:1]],
                                                                 upd_taken_i);
        end
    end

    tage_tagged_table t0_table (
        .clk            (clk),
        .rst            (rst),
        .lookup_index_i (t0_idx),
        .lookup_tag_i   (t0_tag),
        .match_o        (t0_match),
        .ctr_o          (t0_ctr),
        .upd_en_i       (t0_upd_en),
        .upd_index_i    (t0_idx_u),
        .upd_tag_i      (t0_tag_u),
        .upd_taken_i    (upd_taken_i),
        .upd_mode_i     (t0_upd_mode),
        .tag_hit_o      (t0_tag_hit)
    );

    tage_tagged_table t1_table (
        .clk            (clk),
        .rst            (rst),
        .lookup_index_i (t1_idx),
        .lookup_tag_i   (t1_tag),
        .match_o        (t1_match),
        .ctr_o          (t1_ctr),
        .upd_en_i       (t1_upd_en),
        .upd_index_i    (t1_idx_u),
        .upd_tag_i      (t1_tag_u),
        .upd_taken_i    (upd_taken_i),
        .upd_mode_i     (t1_upd_mode),
        .tag_hit_o      (t1_tag_hit)
    );

endmodule

// ==== rtl/tage_tagged_table.sv ====
`timescale 1ns/100ps
`include "bpu_settings.svh"

module tage_tagged_table #(
    parameter int IDX_W = $clog2(`TAGGED_ENTRIES)
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [IDX_W-1:0]       lookup_index_i,
    input  bpu_pred_pkg::tage_tag_t lookup_tag_i,
    output logic                   match_o,
    output bpu_pred_pkg::ctr2_t    ctr_o,
    input  logic                   upd_en_i,
    input  logic [IDX_W-1:0]       upd_index_i,
    input  bpu_pred_pkg::tage_tag_t upd_tag_i,
    input  logic                   upd_taken_i,
    input  bpu_pred_pkg::upd_mode_e upd_mode_i,
    output logic                   tag_hit_o
);

    localparam int PT_LSB = `TAG_WIDTH - `PARTIAL_TAG_BITS;

    bpu_pred_pkg::tage_tag_t tag_mem [`TAGGED_ENTRIES];
    bpu_pred_pkg::ctr2_t     ctr_mem [`TAGGED_ENTRIES];

    // lookup only checks the upper tag bits
    assign match_o = (tag_mem[lookup_index_i][`TAG_WIDTH-1:PT_LSB]
                      == lookup_tag_i[`TAG_WIDTH-1:PT_LSB]);
    assign ctr_o   = ctr_mem[lookup_index_i];

    assign tag_hit_o = (tag_mem[upd_index_i] == upd_tag_i);  // full compare for alloc

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `TAGGED_ENTRIES; i++) begin
                tag_mem[i] <= '0;
                ctr_mem[i] <= bpu_pred_pkg::CTR_WEAK_NT;
            end
        end else if (upd_en_i) begin
            case (upd_mode_i)
                bpu_pred_pkg::UPD_TRAIN:
                    ctr_mem[upd_index_i] <= bpu_pred_pkg::ctr_step(ctr_mem[upd_index_i],
                                                                   upd_taken_i);
                bpu_pred_pkg::UPD_RESET:
                    ctr_mem[upd_index_i] <= upd_taken_i ? bpu_pred_pkg::CTR_STRONG_T
                                                        : bpu_pred_pkg::CTR_STRONG_NT;
                bpu_pred_pkg::UPD_ALLOC: begin
                    tag_mem[upd_index_i] <= upd_tag_i;
                    ctr_mem[upd_index_i] <= upd_taken_i ? bpu_pred_pkg::CTR_WEAK_T
                                                        : bpu_pred_pkg::CTR_WEAK_NT;
                end
                default: ;
            endcase
        end
    end

    upd_index_known: assert property (
        @(posedge clk) disable iff (rst) upd_en_i |-> !$isunknown(upd_index_i)
    );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the branch predictor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f files.f --top-module bpu_tb \
    -o bpu_sim > sim.log 2>&1 \
    && ./obj_dir/bpu_sim >> sim.log 2>&1 \
    || echo "tests failed" >> sim.log

cat sim.log
grep -q "tests failed" sim.log && exit 1
exit 0

// ==== tests/bpu_tb.sv ====
`timescale 1ns/100ps
`include "bpu_settings.svh"

module bpu_tb;

    localparam int MAX_LINES   = 1000;
    localparam int RST_TIMEOUT = 20;

    logic                    clk;
    logic                    rst;
    logic [`XLEN-1:0]        if_pc, if_inst, push_data, ex_pc, ex_target, ex_inst;
    logic                    push_v, stall, br_v, br_taken, pdt_true;
    logic [`HIST_LEN-1:0]    ex_hist;
    bpu_pred_pkg::provider_e ex_prov;
    logic                    bon, pdt_res;
    logic [`XLEN-1:0]        pdt_pc;
    logic [`HIST_LEN-1:0]    hist;
    bpu_pred_pkg::provider_e prov;

    logic [31:0]             lfsr;
    int                      fd, n, line_cnt, guard, wait_cnt;
    logic [8*200-1:0]        line_buf;
    logic [8*32-1:0]         tname;

    // one data line, fields in file order
    logic [`XLEN-1:0]     d_pc, d_inst, d_push_data, d_ex_pc, d_ex_target, d_ex_inst, d_exp_pc;
    logic                 d_push_v, d_stall, d_br_v, d_taken, d_correct, d_exp_bon, d_exp_res;
    logic [`HIST_LEN-1:0] d_ex_hist, d_exp_hist;
    logic [1:0]           d_ex_prov, d_exp_prov;

    bpu_top bpu_top_i (
        .clk                 (clk),
        .rst                 (rst),
        .if_pc_i             (if_pc),
        .if_inst_i           (if_inst),
        .id_ras_push_valid_i (push_v),
        .id_ras_push_data_i  (push_data),
        .ex_stall_valid_i    (stall),
        .ex_branch_valid_i   (br_v),
        .ex_branch_taken_i   (br_taken),
        .ex_pdt_true_i       (pdt_true),
        .ex_pc_i             (ex_pc),
        .ex_history_i        (ex_hist),
        .ex_provider_i       (ex_prov),
        .ex_target_i         (ex_target),
        .ex_inst_i           (ex_inst),
        .branch_or_not_o     (bon),
        .pdt_pc_o            (pdt_pc),
        .pdt_res_o           (pdt_res),
        .history_o           (hist),
        .provider_o          (prov)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    // taps 32,22,2,1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic draw_bits(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            lfsr = lfsr_next(lfsr);
            v    = {v[30:0], lfsr[0]};  // one step per bit
        end
    endtask

    task automatic stop_on_failure(input string why);
        $display("%s", why);
        $display("tests failed");
        $fatal(1);
    endtask

    task automatic check_bit(input logic [8*32-1:0] t, input string what,
                             input logic exp, input logic act);
        if (act !== exp) begin
            $display("** Error %0s: %s expected %b, actual %b", t, what, exp, act);
            stop_on_failure("prediction output mismatch");
        end
    endtask

    task automatic check_addr(input logic [8*32-1:0] t, input string what,
                              input logic [`XLEN-1:0] exp, input logic [`XLEN-1:0] act);
        if (act !== exp) begin
            $display("** Error %0s: %s expected %h, actual %h", t, what, exp, act);
            stop_on_failure("target mismatch");
        end
    endtask

    task automatic check_hist(input logic [8*32-1:0] t,
                              input logic [`HIST_LEN-1:0] exp, input logic [`HIST_LEN-1:0] act);
        if (act !== exp) begin
            $display("** Error %0s: history expected %h, actual %h", t, exp, act);
            stop_on_failure("history mismatch");
        end
    endtask

    task automatic check_provider(input logic [8*32-1:0] t,
                                  input bpu_pred_pkg::provider_e exp,
                                  input bpu_pred_pkg::provider_e act);
        if (act !== exp) begin
            $display("** Error %0s: provider expected %s, actual %s",
                     t, exp.name(), act.name());
            stop_on_failure("provider mismatch");
        end
    endtask

    task automatic apply_line();
        @(negedge clk);
        if_pc     = d_pc;
        if_inst   = d_inst;
        push_v    = d_push_v;
        push_data = d_push_data;
        stall     = d_stall;
        br_v      = d_br_v;
        br_taken  = d_taken;
        pdt_true  = d_correct;
        ex_pc     = d_ex_pc;
        ex_hist   = d_ex_hist;
        ex_prov   = bpu_pred_pkg::provider_e'(d_ex_prov);
        ex_target = d_ex_target;
        ex_inst   = d_ex_inst;
        #4;  // just before the rising edge
        check_bit(tname, "branch_or_not", d_exp_bon, bon);
        check_bit(tname, "pdt_res", d_exp_res, pdt_res);
        check_addr(tname, "pdt_pc", d_exp_pc, pdt_pc);
        check_provider(tname, bpu_pred_pkg::provider_e'(d_exp_prov), prov);
        check_hist(tname, d_exp_hist, hist);
    endtask

    // op-imm word at a random pc, never a control transfer
    task automatic apply_filler();
        logic [31:0] pc_bits, imm_bits;
        draw_bits(30, pc_bits);
        draw_bits(25, imm_bits);
        @(negedge clk);
        if_pc   = {pc_bits[29:0], 2'b00};
        if_inst = {imm_bits[24:0], 7'b0010011};
        push_v  = 1'b0;
        br_v    = 1'b0;
        #4;
        check_bit("filler", "branch_or_not", 1'b0, bon);
        check_bit("filler", "pdt_res", 1'b0, pdt_res);
        check_addr("filler", "pdt_pc", if_pc + `XLEN'd4, pdt_pc);
    endtask

    initial begin
        rst       = 1'b1;
        if_pc     = '0;
        if_inst   = '0;
        push_v    = 1'b0;
        push_data = '0;
        stall     = 1'b0;
        br_v      = 1'b0;
        br_taken  = 1'b0;
        pdt_true  = 1'b0;
        ex_pc     = '0;
        ex_hist   = '0;
        ex_prov   = bpu_pred_pkg::PROV_BIMODAL;
        ex_target = '0;
        ex_inst   = '0;
        lfsr      = 32'h6e96;

        wait_cnt = 0;
        while (rst !== 1'b0 && wait_cnt < RST_TIMEOUT) begin
            @(posedge clk);
            wait_cnt++;
        end
        if (rst !== 1'b0)
            stop_on_failure("reset was never released");

        fd = $fopen("tests/bpu_testdata.txt", "r");
        if (fd == 0)
            stop_on_failure("could not open tests/bpu_testdata.txt");

        line_cnt = 0;
        guard    = 0;
        while (!$feof(fd) && guard < MAX_LINES) begin
            guard++;
            line_buf = '0;
            tname    = '0;
            void'($fgets(line_buf, fd));
            n = $sscanf(line_buf, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        tname, d_pc, d_inst, d_push_v, d_push_data, d_stall, d_br_v,
                        d_taken, d_correct, d_ex_pc, d_ex_hist, d_ex_prov, d_ex_target,
                        d_ex_inst, d_exp_bon, d_exp_res, d_exp_pc, d_exp_prov, d_exp_hist);
            if (n == 19) begin
                apply_line();
                apply_filler();
                line_cnt++;
            end else if (n > 0 && tname != "#") begin
                stop_on_failure("malformed line in the data file");
            end
        end
        if (guard >= MAX_LINES)
            stop_on_failure("data file did not end within the line limit");
        $fclose(fd);

        if (line_cnt == 0) begin
            $display("no data lines were read");
            $display("tests failed");
            $fatal(1);
        end else begin
            $display("all tests passed");
            $finish;
        end
    end

endmodule

// ==== tests/bpu_testdata.txt ====
# name pc inst push push_data stall br_v taken correct ex_pc ex_hist ex_prov ex_target ex_inst
# then expected: branch_or_not pdt_res pdt_pc provider history (all hex, provider 0 bim 1 t0 2 t1)
reset_branch 100 863 0 0 0 0 0 0 0 0 0 0 0 1 0 104 2 0
reset_jal 200 100000ef 0 0 0 0 0 0 0 0 0 0 0 1 1 300 2 0
reset_nop 40 13 0 0 0 0 0 0 0 0 0 0 0 0 0 44 2 0
alloc_lookup 3000 863 0 0 0 0 0 0 0 0 0 0 0 1 0 3004 0 0
alloc_update 40 13 0 0 0 1 1 0 3000 0 0 3010 863 0 0 44 2 0
alloc_hit 3000 863 0 0 0 0 0 0 0 0 0 0 0 1 1 3010 2 1
train_1 40 13 0 0 0 1 1 1 3000 1 2 3010 863 0 0 44 2 1
train_2 40 13 0 0 0 1 1 1 3000 1 2 3010 863 0 0 44 2 3
sat_taken 3000 863 0 0 0 0 0 0 0 0 0 0 0 1 1 3010 2 7
flip_update 40 13 0 0 0 1 0 0 3000 1 2 3004 863 0 0 44 2 7
flip_nt 3000 863 0 0 0 0 0 0 0 0 0 0 0 1 0 3004 2 e
ras_push_a 40 13 1 1004 0 0 0 0 0 0 0 0 0 0 0 44 2 e
ras_push_b 40 13 1 2008 0 0 0 0 0 0 0 0 0 0 0 44 2 e
ras_stall 600 8067 1 5555 1 0 0 0 0 0 0 0 0 1 1 2008 1 e
ras_pop 600 8067 0 0 0 1 1 1 600 e 1 2008 8067 1 1 2008 1 e
ras_next 600 8067 0 0 0 0 0 0 0 0 0 0 0 1 1 1004 1 1d
ras_drain 40 13 0 0 0 1 1 1 600 1d 1 1004 8067 0 0 44 1 1d
ret_btb 600 8067 0 0 0 0 0 0 0 0 0 0 0 1 1 1004 2 3b
ret_miss 700 8067 0 0 0 0 0 0 0 0 0 0 0 1 0 704 2 3b
hist_t1 40 13 0 0 0 1 1 1 900 3b 0 980 863 0 0 44 1 3b
hist_n 40 13 0 0 0 1 0 1 900 77 0 904 863 0 0 44 1 77
hist_t2 40 13 0 0 0 1 1 1 900 ee 0 980 863 0 0 44 1 ee
hist_t3 40 13 0 0 0 1 1 1 900 1dd 0 980 863 0 0 44 1 1dd
hist_final 40 13 0 0 0 0 0 0 0 0 0 0 0 0 0 44 1 3bb
